// File: src/rv_core_fsm.sv
/*
  rv_mini core sequencer
  runs fetch, execute and store handshakes and halts on ecall or a bad opcode
*/
`timescale 1ns/10ps

module rv_core_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                fetch_ack,
    input  logic                data_ack,
    input  rv_mini_pkg::opcode_e opcode,
    output logic                fetch_req,
    output logic                data_req,
    output logic                ir_load,
    output logic                pc_inc,
    output logic                rf_we,
    output logic                done,
    output logic                trap
);
    import rv_mini_pkg::*;

    core_state_e state;
    logic        is_alu;

    assign is_alu = (opcode == op_reg) || (opcode == op_imm);

    // instruction word is valid while the fetch ack is up
    assign ir_load = (state == st_fetch) && fetch_req && fetch_ack;
    assign rf_we   = (state == st_exec) && is_alu;

    // retire on alu writeback or once the store handshake has closed
    assign pc_inc = ((state == st_exec) && is_alu) ||
                    ((state == st_store) && !data_req && !data_ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            fetch_req <= 1'b0;
            data_req  <= 1'b0;
            done      <= 1'b0;
            trap      <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (run) begin
                        state     <= st_fetch;
                        fetch_req <= 1'b1;
                    end
                end
                // drop req on ack, then wait for the ack to fall
                st_fetch: begin
                    if (fetch_req && fetch_ack) begin
                        fetch_req <= 1'b0;
                    end else if (!fetch_req && !fetch_ack) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    case (opcode)
                        op_reg, op_imm: begin
                            state     <= st_fetch;
                            fetch_req <= 1'b1;
                        end
                        op_store: begin
                            state    <= st_store;
                            data_req <= 1'b1;
                        end
                        op_system: begin
                            state <= st_halt;
                            done  <= 1'b1;
                        end
                        default: begin
                            state <= st_halt;
                            done  <= 1'b1;
                            trap  <= 1'b1;
                        end
                    endcase
                end
                st_store: begin
                    if (data_req && data_ack) begin
                        data_req <= 1'b0;
                    end else if (!data_req && !data_ack) begin
                        state     <= st_fetch;
                        fetch_req <= 1'b1;
                    end
                end
                st_halt: begin
                    if (!run) begin
                        state <= st_idle;
                        done  <= 1'b0;
                        trap  <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // only one core request open at a time
    assert property (@(posedge clk) disable iff (rst) !(fetch_req && data_req));

    // halt status holds until run is released
    assert property (@(posedge clk) disable iff (rst) done && run |=> done);

endmodule

// File: src/rv_exec_unit.sv
/*
  rv_mini execute unit
  instruction register, decode, immediates and the shared adder
*/
`timescale 1ns/10ps

module rv_exec_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ir_load,
    input  logic [rv_mini_pkg::xlen-1:0]   rd_data,
    input  logic [rv_mini_pkg::xlen-1:0]   rs1_data,
    input  logic [rv_mini_pkg::xlen-1:0]   rs2_data,
    output rv_mini_pkg::opcode_e          opcode,
    output logic [4:0]                    rs1_sel,
    output logic [4:0]                    rs2_sel,
    output logic [4:0]                    rd_sel,
    output logic [rv_mini_pkg::xlen-1:0]   wb_data,
    output logic [rv_mini_pkg::mem_aw-1:0] store_addr,
    output logic [rv_mini_pkg::xlen-1:0]   store_data
);
    import rv_mini_pkg::*;

    logic [xlen-1:0] ir;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] sum;
    logic            legal;

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= rd_data;
        end
    end

    // --------------------------------------------------
    // decode
    // --------------------------------------------------

    // funct fields must match too, ecall needs all upper bits clear
    always_comb begin
        case (ir[6:0])
            op_reg:    legal = (ir[14:12] == 3'b000) && (ir[31:25] == 7'b0000000);
            op_imm:    legal = (ir[14:12] == 3'b000);
            op_store:  legal = (ir[14:12] == 3'b010);
            op_system: legal = (ir[31:7] == 25'd0);
            default:   legal = 1'b0;
        endcase
    end

    // illegal words show up as a value outside the enum
    assign opcode = legal ? opcode_e'(ir[6:0]) : opcode_e'(7'h00);

    assign rs1_sel = ir[19:15];
    assign rs2_sel = ir[24:20];
    assign rd_sel  = ir[11:7];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};

    // --------------------------------------------------
    // adder
    // --------------------------------------------------

    always_comb begin
        case (opcode)
            op_reg:   operand_b = rs2_data;
            op_store: operand_b = imm_s;
            default:  operand_b = imm_i;
        endcase
    end

    assign sum     = rs1_data + operand_b;
    assign wb_data = sum;

    // byte address down to a word address
    assign store_addr = sum[mem_aw+1:2];
    assign store_data = rs2_data;

endmodule

// File: src/rv_mem_arbiter.sv
/*
  rv_mini memory arbiter
  three four-phase req/ack ports, priority data, host, fetch
*/
`timescale 1ns/10ps

module rv_mem_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_req,
    input  logic [rv_mini_pkg::mem_aw-1:0] fetch_addr,
    output logic                          fetch_ack,
    output logic [rv_mini_pkg::xlen-1:0]   rd_data,
    input  logic                          data_req,
    input  logic [rv_mini_pkg::mem_aw-1:0] data_addr,
    input  logic [rv_mini_pkg::xlen-1:0]   data_wdata,
    output logic                          data_ack,
    input  logic                          host_req,
    input  logic                          host_we,
    input  logic [rv_mini_pkg::mem_aw-1:0] host_addr,
    input  logic [rv_mini_pkg::xlen-1:0]   host_wdata,
    output logic                          host_ack,
    output logic [rv_mini_pkg::xlen-1:0]   host_rdata,
    output logic                          mem_en,
    output logic                          mem_we,
    output logic [rv_mini_pkg::mem_aw-1:0] mem_addr,
    output logic [rv_mini_pkg::xlen-1:0]   mem_wdata,
    input  logic [rv_mini_pkg::xlen-1:0]   mem_rdata
);
    import rv_mini_pkg::*;

    typedef enum logic [1:0] {
        arb_idle,
        arb_mem,
        arb_ack
    } arb_state_e;

    arb_state_e state;
    logic       gnt_data;
    logic       gnt_host;
    logic       gnt_fetch;
    logic       owner_req;

    assign owner_req = (gnt_data & data_req) | (gnt_host & host_req) |
                       (gnt_fetch & fetch_req);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= arb_idle;
            gnt_data  <= 1'b0;
            gnt_host  <= 1'b0;
            gnt_fetch <= 1'b0;
            data_ack  <= 1'b0;
            host_ack  <= 1'b0;
            fetch_ack <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    gnt_data  <= data_req;
                    gnt_host  <= host_req & ~data_req;
                    gnt_fetch <= fetch_req & ~data_req & ~host_req;
                    if (data_req || host_req || fetch_req) begin
                        state <= arb_mem;
                    end
                end
                // memory access this cycle, data back with the ack
                arb_mem: begin
                    data_ack  <= gnt_data;
                    host_ack  <= gnt_host;
                    fetch_ack <= gnt_fetch;
                    state     <= arb_ack;
                end
                arb_ack: begin
                    if (!owner_req) begin
                        data_ack  <= 1'b0;
                        host_ack  <= 1'b0;
                        fetch_ack <= 1'b0;
                        state     <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    assign mem_en    = (state == arb_mem);
    assign mem_we    = gnt_data | (gnt_host & host_we);
    assign mem_addr  = gnt_data ? data_addr : (gnt_host ? host_addr : fetch_addr);
    assign mem_wdata = gnt_data ? data_wdata : host_wdata;

    assign rd_data    = mem_rdata;
    assign host_rdata = mem_rdata;

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({data_ack, host_ack, fetch_ack}));

    // every ack answers a request that is still up
    assert property (@(posedge clk) disable iff (rst) $rose(data_ack) |-> data_req);
    assert property (@(posedge clk) disable iff (rst) $rose(host_ack) |-> host_req);
    assert property (@(posedge clk) disable iff (rst) $rose(fetch_ack) |-> fetch_req);

endmodule

// File: src/rv_mini_pkg.sv
/*
  rv_mini package
  shared widths, memory depth, opcode field values and sequencer states
*/
package rv_mini_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------

    // data path width
    localparam int xlen = 32;

    // word memory depth and its address width
    localparam int mem_words = 256;
    localparam int mem_aw = 8;

    // byte address of the first fetch
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------

    // 7-bit major opcode field, the four supported classes
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_system = 7'b1110011
    } opcode_e;

    // core sequencer
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_store,
        st_halt
    } core_state_e;

endpackage

// File: src/rv_mini_top.sv
/*
  rv_mini top level
  core sequencer, pc, register file, execute unit, arbiter and word memory
*/
`timescale 1ns/10ps

module rv_mini_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          run,
    output logic                          done,
    output logic                          trap,
    input  logic                          host_req,
    input  logic                          host_we,
    input  logic [rv_mini_pkg::mem_aw-1:0] host_addr,
    input  logic [rv_mini_pkg::xlen-1:0]   host_wdata,
    output logic                          host_ack,
    output logic [rv_mini_pkg::xlen-1:0]   host_rdata
);
    import rv_mini_pkg::*;

    // core control
    opcode_e           opcode;
    logic              fetch_req;
    logic              fetch_ack;
    logic              data_req;
    logic              data_ack;
    logic              ir_load;
    logic              pc_inc;
    logic              rf_we;
    logic [mem_aw-1:0] pc;
    logic [15:0]       retired;

    // data path
    logic [4:0]        rs1_sel;
    logic [4:0]        rs2_sel;
    logic [4:0]        rd_sel;
    logic [xlen-1:0]   rs1_data;
    logic [xlen-1:0]   rs2_data;
    logic [xlen-1:0]   wb_data;
    logic [xlen-1:0]   rd_data;
    logic [mem_aw-1:0] store_addr;
    logic [xlen-1:0]   store_data;

    // memory side
    logic              mem_en;
    logic              mem_we;
    logic [mem_aw-1:0] mem_addr;
    logic [xlen-1:0]   mem_wdata;
    logic [xlen-1:0]   mem_rdata;

    rv_core_fsm rv_core_fsm_i (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .fetch_ack (fetch_ack),
        .data_ack  (data_ack),
        .opcode    (opcode),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .ir_load   (ir_load),
        .pc_inc    (pc_inc),
        .rf_we     (rf_we),
        .done      (done),
        .trap      (trap)
    );

    // pc held at the start address while run is low
    rv_pc_counter rv_pc_counter_i (
        .clk     (clk),
        .rst     (rst),
        .clear   (!run),
        .pc_inc  (pc_inc),
        .pc      (pc),
        .retired (retired)
    );

    rv_regfile rv_regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .rd_sel   (rd_sel),
        .we       (rf_we),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_exec_unit rv_exec_unit_i (
        .clk        (clk),
        .rst        (rst),
        .ir_load    (ir_load),
        .rd_data    (rd_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .opcode     (opcode),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .rd_sel     (rd_sel),
        .wb_data    (wb_data),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    rv_mem_arbiter rv_mem_arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (pc),
        .fetch_ack  (fetch_ack),
        .rd_data    (rd_data),
        .data_req   (data_req),
        .data_addr  (store_addr),
        .data_wdata (store_data),
        .data_ack   (data_ack),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    rv_sram rv_sram_i (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // --------------------------------------------------
    // cross-block checks
    // --------------------------------------------------

    // one word per retired instruction and no wrap past the last word
    assert property (@(posedge clk) disable iff (rst)
        !fetch_req |-> (16'(pc) == retired));

endmodule

// File: src/rv_pc_counter.sv
/* rv_mini program counter, word addressed, with a retired instruction count */
`timescale 1ns/10ps

module rv_pc_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear,
    input  logic                          pc_inc,
    output logic [rv_mini_pkg::mem_aw-1:0] pc,
    output logic [15:0]                   retired
);
    import rv_mini_pkg::*;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            // start address is a byte address, pc counts words
            pc      <= reset_pc[mem_aw+1:2];
            retired <= '0;
        end else if (pc_inc) begin
            pc      <= pc + 1'b1;
            retired <= retired + 1'b1;
        end
    end

endmodule

// File: src/rv_regfile.sv
/* rv_mini register file, 32 entries, two async reads, one sync write, x0 reads zero */
`timescale 1ns/10ps

module rv_regfile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [4:0]                  rs1_sel,
    input  logic [4:0]                  rs2_sel,
    input  logic [4:0]                  rd_sel,
    input  logic                        we,
    input  logic [rv_mini_pkg::xlen-1:0] wdata,
    output logic [rv_mini_pkg::xlen-1:0] rs1_data,
    output logic [rv_mini_pkg::xlen-1:0] rs2_data
);
    import rv_mini_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_sel != 5'd0)) begin
            // x0 never takes a write
            regs[rd_sel] <= wdata;
        end
    end

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

endmodule

// File: src/rv_sram.sv
/* rv_mini word memory, single port, registered read one cycle after en */
`timescale 1ns/10ps

module rv_sram (
    input  logic                          clk,
    input  logic                          en,
    input  logic                          we,
    input  logic [rv_mini_pkg::mem_aw-1:0] addr,
    input  logic [rv_mini_pkg::xlen-1:0]   wdata,
    output logic [rv_mini_pkg::xlen-1:0]   rdata
);
    import rv_mini_pkg::*;

    logic [xlen-1:0] mem [mem_words];

    // read returns the old word on a write
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

// File: tb.f
src/rv_mini_pkg.sv
src/rv_core_fsm.sv
src/rv_pc_counter.sv
src/rv_regfile.sv
src/rv_exec_unit.sv
src/rv_mem_arbiter.sv
src/rv_sram.sv
src/rv_mini_top.sv
tests/tb_rv_mini.sv

// File: tests/rv_mini_stim.txt
# name nwords program_words(hex) runs trap nchk then nchk pairs of word_addr(hex) expected(hex)
# doubler and host_rw are filled in by the testbench from its random source
host_rw 0 0 0 0
doubler 0 1 0 0
fib 24
00000093 00100113
002081b3 00010093 00018113
002081b3 00010093 00018113
002081b3 00010093 00018113
002081b3 00010093 00018113
002081b3 00010093 00018113
002081b3 00010093 00018113
32102223 32202423 32302623 00000073
1 0 3 c9 00000008 ca 0000000d cb 0000000d
x0_write 3 00500013 32002823 00000073 1 0 1 cc 00000000
illegal 5 00700093 32102a23 ffffffff 32102c23 00000073 1 1 2 cd 00000007 ce a5ce5a31
restart 24
00000093 00100113
002081b3 00010093 00018113
002081b3 00010093 00018113
002081b3 00010093 00018113
002081b3 00010093 00018113
002081b3 00010093 00018113
002081b3 00010093 00018113
32102223 32202423 32302623 00000073
2 0 3 c9 00000008 ca 0000000d cb 0000000d

// File: tests/tb_rv_mini.sv
/*
  rv_mini testbench
  loads programs over the host port, runs them and checks the stored words
*/
`timescale 1ns/10ps

module tb_rv_mini;
    import rv_mini_pkg::*;

    localparam int          clk_period      = 4;
    localparam int          reset_cycles    = 8;
    localparam int          timeout_base    = 2000;
    localparam int          cycles_per_word = 8;
    localparam int          host_words      = 8;
    localparam logic [31:0] seed            = 32'hadcd;

    logic              clk;
    logic              rst;
    logic              run;
    logic              done;
    logic              trap;
    logic              host_req;
    logic              host_we;
    logic [mem_aw-1:0] host_addr;
    logic [xlen-1:0]   host_wdata;
    logic              host_ack;
    logic [xlen-1:0]   host_rdata;

    int          cycles = 0;
    int          limit;
    int          pass_count;
    int          fail_count;
    int          err_count;
    string       waiting_on;
    logic [31:0] rng;

    // current test record
    logic [xlen-1:0]   prog [$];
    logic [mem_aw-1:0] chk_addr [$];
    logic [xlen-1:0]   chk_exp [$];

    rv_mini_top rv_mini_top_i (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .done       (done),
        .trap       (trap),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata)
    );

    always #(clk_period / 2) clk = ~clk;

    // watchdog limit grows with every program loaded
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, no response while waiting for %s",
                     cycles, waiting_on);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // reference helpers
    // --------------------------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // marker for words that a run must leave alone
    function automatic logic [xlen-1:0] fill_word(input logic [mem_aw-1:0] a);
        return {8'ha5, a, 8'h5a, ~a};
    endfunction

    // RV32I I, R and S formats
    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------

    task automatic check_word(input string test, input logic [mem_aw-1:0] addr,
                              input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s word %0d expected %h actual %h",
                     test, addr, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_flags(input string test, input logic exp_done, input logic exp_trap,
                               input logic act_done, input logic act_trap);
        if ((act_done !== exp_done) || (act_trap !== exp_trap)) begin
            $display("CHECK FAILED %s done,trap expected %b,%b actual %b,%b",
                     test, exp_done, exp_trap, act_done, act_trap);
            err_count++;
        end
    endtask

    // --------------------------------------------------
    // host port and run control
    // --------------------------------------------------

    // four-phase cycle started on a rising edge
    task automatic mem_handshake(input logic we, input logic [mem_aw-1:0] addr,
                                 input logic [xlen-1:0] wdata, output logic [xlen-1:0] rdata);
        waiting_on = "host ack";
        host_req   <= 1'b1;
        host_we    <= we;
        host_addr  <= addr;
        host_wdata <= wdata;
        @(posedge clk);
        while (!host_ack) @(posedge clk);
        rdata = host_rdata;
        host_req   <= 1'b0;
        waiting_on = "host ack to fall";
        @(posedge clk);
        while (host_ack) @(posedge clk);
        waiting_on = "nothing";
    endtask

    task automatic host_write(input logic [mem_aw-1:0] addr, input logic [xlen-1:0] data);
        logic [xlen-1:0] ignored;
        mem_handshake(1'b1, addr, data, ignored);
    endtask

    task automatic host_read(input logic [mem_aw-1:0] addr, output logic [xlen-1:0] data);
        mem_handshake(1'b0, addr, '0, data);
    endtask

    task automatic run_once(input string test, input logic exp_trap);
        waiting_on = "done";
        run <= 1'b1;
        @(posedge clk);
        while (!done) @(posedge clk);
        // halt flags must hold while run stays high
        @(posedge clk);
        check_flags(test, 1'b1, exp_trap, done, trap);
        run <= 1'b0;
        waiting_on = "done to fall";
        @(posedge clk);
        while (done) @(posedge clk);
        waiting_on = "nothing";
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------

    task automatic random_host_test(input string test);
        logic [mem_aw-1:0] addrs [$];
        logic [xlen-1:0]   model [mem_words];
        logic [xlen-1:0]   word;
        for (int k = 0; k < host_words; k++) begin
            rng = xorshift(rng);
            addrs.push_back(rng[mem_aw-1:0]);
            rng = xorshift(rng);
            model[addrs[k]] = rng;
            host_write(addrs[k], rng);
        end
        // last write to an address wins
        foreach (addrs[k]) begin
            host_read(addrs[k], word);
            check_word(test, addrs[k], model[addrs[k]], word);
        end
    endtask

    // x1 = 1, doubled n times, stored to word 200
    task automatic build_doubler();
        int n;
        rng = xorshift(rng);
        n = 4 + int'(rng % 24);
        prog.push_back(enc_addi(5'd1, 5'd0, 12'd1));
        repeat (n) prog.push_back(enc_add(5'd1, 5'd1, 5'd1));
        prog.push_back(enc_sw(5'd1, 5'd0, 12'd800));
        prog.push_back(32'h0000_0073);
        chk_addr.push_back(8'd200);
        chk_exp.push_back(32'd1 << n);
        $display("doubler runs %0d doublings", n);
    endtask

    task automatic program_test(input string test, input int runs, input logic exp_trap);
        logic [xlen-1:0] word;
        limit = limit + cycles_per_word * prog.size();
        foreach (prog[i]) host_write(mem_aw'(i), prog[i]);
        for (int r = 0; r < runs; r++) begin
            // preload so that a missing store shows up
            foreach (chk_addr[j]) host_write(chk_addr[j], fill_word(chk_addr[j]));
            run_once(test, exp_trap);
            foreach (chk_addr[j]) begin
                host_read(chk_addr[j], word);
                check_word(test, chk_addr[j], chk_exp[j], word);
            end
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial begin
        int                fd;
        int                code;
        int                nwords;
        int                runs;
        int                exp_trap;
        int                nchk;
        string             name;
        logic [8*256-1:0]  line;
        logic [xlen-1:0]   word;
        logic [mem_aw-1:0] addr;
        clk        = 1'b0;
        rst        = 1'b1;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        rng        = seed;
        limit      = timeout_base;
        pass_count = 0;
        fail_count = 0;
        waiting_on = "reset";
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        fd = $fopen("tests/rv_mini_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/rv_mini_stim.txt");
            fail_count++;
        end else begin
            while ($fscanf(fd, "%s", name) == 1) begin
                if (name.substr(0, 0) == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    prog.delete();
                    chk_addr.delete();
                    chk_exp.delete();
                    code = $fscanf(fd, "%d", nwords);
                    for (int i = 0; i < nwords; i++) begin
                        code = $fscanf(fd, "%h", word);
                        prog.push_back(word);
                    end
                    code = $fscanf(fd, "%d %d %d", runs, exp_trap, nchk);
                    for (int i = 0; i < nchk; i++) begin
                        code = $fscanf(fd, "%h %h", addr, word);
                        chk_addr.push_back(addr);
                        chk_exp.push_back(word);
                    end
                    err_count = 0;
                    if (name == "host_rw") begin
                        random_host_test(name);
                    end else begin
                        if (name == "doubler") begin
                            build_doubler();
                        end
                        program_test(name, runs, exp_trap != 0);
                    end
                    if (err_count == 0) begin
                        $display("test %s passed", name);
                        pass_count++;
                    end else begin
                        $display("test %s failed with %0d errors", name, err_count);
                        fail_count++;
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
